/* Bender.yml */
package:
  name: dram_sniffer

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/sniffer_pkg.sv
      - logic/dram_req_if.sv
      - logic/host_window.sv
      - logic/dram_arbiter.sv
      - logic/dram_cmd_stage.sv
      - logic/dram_sniffer_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_dram_sniffer.sv

/* logic/dram_arbiter.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

module dram_arbiter (
  input  logic                    dram_clk,
  input  logic                    reset,
  input  logic                    phy_ready,
  input  logic                    stage_take,
  input  sniffer_pkg::dram_word_u dram_rd_data,
  input  logic                    dram_rd_valid,
  output logic                    grant_valid,
  output logic [`SNIF_ADDR_W-1:0] grant_addr,
  output logic                    grant_rnw,
  output sniffer_pkg::dram_word_u grant_data,
  output logic [`SNIF_BE_W-1:0]   grant_be,
  dram_req_if.arbiter             app,
  dram_req_if.arbiter             host
);
  import sniffer_pkg::*;

  localparam int PTR_W = $clog2(`SNIF_RD_DEPTH);

  req_id_e          owner_q [`SNIF_RD_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;
  logic             q_full;
  logic             q_empty;
  logic             push;
  logic             pop;
  req_id_e          head;
  logic             app_ok;
  logic             host_ok;
  logic             pick_app;
  logic             pick_host;
  logic             prefer_host;
  req_id_e          grant_id;

  ////////////////////
  // request selection.
  // a read is held back while no owner slot is free.
  assign app_ok  = app.cmd_valid && !(app.cmd_rnw && q_full);
  assign host_ok = host.cmd_valid && !(host.cmd_rnw && q_full);

  assign pick_app  = stage_take && phy_ready && app_ok && (!host_ok || !prefer_host);
  assign pick_host = stage_take && phy_ready && host_ok && !pick_app;

  assign grant_id    = pick_host ? REQ_HOST : REQ_APP;
  assign grant_valid = pick_app || pick_host;
  assign grant_addr  = (grant_id == REQ_HOST) ? host.cmd_addr : app.cmd_addr;
  assign grant_rnw   = (grant_id == REQ_HOST) ? host.cmd_rnw : app.cmd_rnw;
  assign grant_data  = (grant_id == REQ_HOST) ? host.wr_data : app.wr_data;
  assign grant_be    = (grant_id == REQ_HOST) ? host.wr_be : app.wr_be;

  assign app.ack  = pick_app;
  assign host.ack = pick_host;

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      prefer_host <= 1'b0;  // application port goes first.
    end else if (grant_valid) begin
      prefer_host <= (grant_id == REQ_APP);
    end
  end

  ////////////////////
  // read owner queue.
  assign push    = grant_valid && grant_rnw;
  assign pop     = dram_rd_valid && !q_empty;
  assign q_full  = (count == `SNIF_RD_DEPTH);
  assign q_empty = (count == '0);
  assign head    = owner_q[rd_ptr];

  always_ff @(posedge dram_clk) begin
    if (push) begin
      owner_q[wr_ptr] <= grant_id;
    end
  end

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // data goes to both, only the owner sees the strobe.
  assign app.rd_data   = dram_rd_data;
  assign host.rd_data  = dram_rd_data;
  assign app.rd_valid  = pop && (head == REQ_APP);
  assign host.rd_valid = pop && (head == REQ_HOST);

  a_rd_owned: assert property (
    @(posedge dram_clk) disable iff (reset) dram_rd_valid |-> !q_empty
  ) else $error("read data with no outstanding read");

  a_no_overflow: assert property (
    @(posedge dram_clk) disable iff (reset) push |-> !q_full
  ) else $error("read owner queue overflow");

  a_one_ack: assert property (
    @(posedge dram_clk) disable iff (reset) !(app.ack && host.ack)
  ) else $error("both requestors acked");

endmodule

/* logic/dram_cmd_stage.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

module dram_cmd_stage (
  input  logic                    dram_clk,
  input  logic                    reset,
  input  logic                    grant_valid,
  input  logic [`SNIF_ADDR_W-1:0] grant_addr,
  input  logic                    grant_rnw,
  input  sniffer_pkg::dram_word_u grant_data,
  input  logic [`SNIF_BE_W-1:0]   grant_be,
  input  logic                    dram_fifo_ready,
  output logic                    stage_take,
  output logic [`SNIF_ADDR_W-1:0] dram_cmd_addr,
  output logic                    dram_cmd_rnw,
  output logic                    dram_cmd_valid,
  output logic [`SNIF_WORD_W-1:0] dram_wr_data,
  output logic [`SNIF_BE_W-1:0]   dram_wr_be
);

  // free now, or emptied by the controller on this edge.
  assign stage_take = !dram_cmd_valid || dram_fifo_ready;

  always_ff @(posedge dram_clk) begin
    if (reset) begin
      dram_cmd_valid <= 1'b0;
    end else if (stage_take) begin
      dram_cmd_valid <= grant_valid;
    end
  end

  always_ff @(posedge dram_clk) begin
    if (stage_take && grant_valid) begin
      dram_cmd_addr <= grant_addr;
      dram_cmd_rnw  <= grant_rnw;
      dram_wr_data  <= grant_data.raw;
      dram_wr_be    <= grant_be;
    end
  end

  a_cmd_hold: assert property (
    @(posedge dram_clk) disable iff (reset)
    dram_cmd_valid && !dram_fifo_ready |=> dram_cmd_valid &&
      $stable(dram_cmd_addr) && $stable(dram_cmd_rnw) &&
      $stable(dram_wr_data) && $stable(dram_wr_be)
  ) else $error("dram command changed under back-pressure");

endmodule

/* logic/dram_req_if.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

interface dram_req_if;
  import sniffer_pkg::*;

  logic [`SNIF_ADDR_W-1:0] cmd_addr;
  logic                    cmd_rnw;
  logic                    cmd_valid;  // held until ack.
  dram_word_u              wr_data;
  logic [`SNIF_BE_W-1:0]   wr_be;
  logic                    ack;        // single cycle, command taken.
  dram_word_u              rd_data;
  logic                    rd_valid;   // single cycle per read, in issue order.

  modport requestor (
    output cmd_addr, cmd_rnw, cmd_valid, wr_data, wr_be,
    input  ack, rd_data, rd_valid
  );

  modport arbiter (
    input  cmd_addr, cmd_rnw, cmd_valid, wr_data, wr_be,
    output ack, rd_data, rd_valid
  );

endinterface

/* logic/dram_sniffer_top.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

module dram_sniffer_top (
  input  logic                    dram_clk,
  input  logic                    reset,
  input  logic                    phy_ready,
  // memory controller side.
  output logic [`SNIF_ADDR_W-1:0] dram_cmd_addr,
  output logic                    dram_cmd_rnw,
  output logic                    dram_cmd_valid,
  output logic [`SNIF_WORD_W-1:0] dram_wr_data,
  output logic [`SNIF_BE_W-1:0]   dram_wr_be,
  input  logic [`SNIF_WORD_W-1:0] dram_rd_data,
  input  logic                    dram_rd_valid,
  input  logic                    dram_fifo_ready,
  // application port.
  input  logic [`SNIF_ADDR_W-1:0] app_cmd_addr,
  input  logic                    app_cmd_rnw,
  input  logic                    app_cmd_valid,
  output logic                    app_cmd_ack,
  input  logic [`SNIF_WORD_W-1:0] app_wr_data,
  input  logic [`SNIF_BE_W-1:0]   app_wr_be,
  output logic [`SNIF_WORD_W-1:0] app_rd_data,
  output logic                    app_rd_valid,
  // host register port.
  input  logic                    host_wr,
  input  logic                    host_rd,
  input  sniffer_pkg::host_reg_e  host_reg,
  input  sniffer_pkg::lane_t      host_wdata,
  output sniffer_pkg::lane_t      host_rdata
);
  import sniffer_pkg::*;

  dram_req_if app_req ();
  dram_req_if host_req ();

  logic                    grant_valid;
  logic [`SNIF_ADDR_W-1:0] grant_addr;
  logic                    grant_rnw;
  dram_word_u              grant_data;
  logic [`SNIF_BE_W-1:0]   grant_be;
  logic                    stage_take;

  ////////////////////
  // application port.
  assign app_req.cmd_addr    = app_cmd_addr << 2;  // word address to byte address.
  assign app_req.cmd_rnw     = app_cmd_rnw;
  assign app_req.cmd_valid   = app_cmd_valid;
  assign app_req.wr_data.raw = app_wr_data;
  assign app_req.wr_be       = app_wr_be;
  assign app_cmd_ack         = app_req.ack;
  assign app_rd_data         = app_req.rd_data.raw;
  assign app_rd_valid        = app_req.rd_valid;

  host_window u_host_window (
    .dram_clk   (dram_clk),
    .reset      (reset),
    .phy_ready  (phy_ready),
    .host_wr    (host_wr),
    .host_rd    (host_rd),
    .host_reg   (host_reg),
    .host_wdata (host_wdata),
    .host_rdata (host_rdata),
    .req        (host_req)
  );

  dram_arbiter u_dram_arbiter (
    .dram_clk      (dram_clk),
    .reset         (reset),
    .phy_ready     (phy_ready),
    .stage_take    (stage_take),
    .dram_rd_data  (dram_rd_data),
    .dram_rd_valid (dram_rd_valid),
    .grant_valid   (grant_valid),
    .grant_addr    (grant_addr),
    .grant_rnw     (grant_rnw),
    .grant_data    (grant_data),
    .grant_be      (grant_be),
    .app           (app_req),
    .host          (host_req)
  );

  dram_cmd_stage u_dram_cmd_stage (
    .dram_clk        (dram_clk),
    .reset           (reset),
    .grant_valid     (grant_valid),
    .grant_addr      (grant_addr),
    .grant_rnw       (grant_rnw),
    .grant_data      (grant_data),
    .grant_be        (grant_be),
    .dram_fifo_ready (dram_fifo_ready),
    .stage_take      (stage_take),
    .dram_cmd_addr   (dram_cmd_addr),
    .dram_cmd_rnw    (dram_cmd_rnw),
    .dram_cmd_valid  (dram_cmd_valid),
    .dram_wr_data    (dram_wr_data),
    .dram_wr_be      (dram_wr_be)
  );

endmodule

/* logic/host_window.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

module host_window (
  input  logic                   dram_clk,
  input  logic                   reset,
  input  logic                   phy_ready,
  input  logic                   host_wr,
  input  logic                   host_rd,
  input  sniffer_pkg::host_reg_e host_reg,
  input  sniffer_pkg::lane_t     host_wdata,
  output sniffer_pkg::lane_t     host_rdata,
  dram_req_if.requestor          req
);
  import sniffer_pkg::*;

  dram_word_u              stage_word;  // staged write or returned read.
  logic [`SNIF_BE_W-1:0]   be_q;
  logic [`SNIF_PAGE_W-1:0] page_q;
  logic [`SNIF_OFFS_W-1:0] offs_q;
  logic                    rnw_q;
  logic                    valid_q;
  logic                    busy;
  logic                    field_wr;
  logic                    start;
  lane_t                   rd_mux;

  // fields are frozen while a command waits for its ack.
  assign field_wr = host_wr && !valid_q;
  assign start    = host_wr && (host_reg == HREG_OFFS) && host_wdata[34] && !busy;

  ////////////////////
  // register file.
  always_ff @(posedge dram_clk) begin
    if (field_wr) begin
      case (host_reg)
        HREG_LANE0: stage_word.lane[0] <= host_wdata;
        HREG_LANE1: stage_word.lane[1] <= host_wdata;
        HREG_LANE2: stage_word.lane[2] <= host_wdata;
        HREG_LANE3: stage_word.lane[3] <= host_wdata;
        HREG_BE:    be_q <= host_wdata[`SNIF_BE_W-1:0];
        HREG_PAGE:  page_q <= host_wdata[`SNIF_PAGE_W-1:0];
        HREG_OFFS:  offs_q <= host_wdata[`SNIF_OFFS_W-1:0];
        default: ;
      endcase
    end
    if (start) begin
      rnw_q <= host_wdata[35];  // bit 35 selects a read.
    end
    if (req.rd_valid) begin
      stage_word <= req.rd_data;  // returned word wins over a lane write.
    end
    if (host_rd) begin
      host_rdata <= rd_mux;
    end
  end

  always_comb begin
    rd_mux = '0;
    case (host_reg)
      HREG_LANE0:  rd_mux = stage_word.lane[0];
      HREG_LANE1:  rd_mux = stage_word.lane[1];
      HREG_LANE2:  rd_mux = stage_word.lane[2];
      HREG_LANE3:  rd_mux = stage_word.lane[3];
      HREG_BE:     rd_mux[`SNIF_BE_W-1:0] = be_q;
      HREG_PAGE:   rd_mux[`SNIF_PAGE_W-1:0] = page_q;
      HREG_OFFS: begin
        rd_mux[`SNIF_OFFS_W-1:0] = offs_q;
        rd_mux[35]               = rnw_q;
      end
      HREG_STATUS: rd_mux[1:0] = {phy_ready, busy};
    endcase
  end

  ////////////////////
  // command control.
  always_ff @(posedge dram_clk) begin
    if (reset) begin
      valid_q <= 1'b0;
      busy    <= 1'b0;
    end else if (start) begin
      valid_q <= 1'b1;
      busy    <= 1'b1;
    end else begin
      if (req.ack) begin
        valid_q <= 1'b0;
      end
      // a write is done at its ack, a read when its data is back.
      if ((req.ack && !rnw_q) || req.rd_valid) begin
        busy <= 1'b0;
      end
    end
  end

  assign req.cmd_addr  = {page_q, offs_q, 2'b00};
  assign req.cmd_rnw   = rnw_q;
  assign req.cmd_valid = valid_q;
  assign req.wr_data   = stage_word;
  assign req.wr_be     = be_q;

  a_req_hold: assert property (
    @(posedge dram_clk) disable iff (reset)
    req.cmd_valid && !req.ack |=> req.cmd_valid && $stable(req.cmd_addr) &&
      $stable(req.cmd_rnw) && $stable(req.wr_data) && $stable(req.wr_be)
  ) else $error("host command changed before ack");

endmodule

/* logic/sniffer_config.svh */
`ifndef SNIFFER_CONFIG_SVH
`define SNIFFER_CONFIG_SVH

////////////////////
// dram command port.
`define SNIF_ADDR_W 32
`define SNIF_WORD_W 144
`define SNIF_BE_W 18

////////////////////
// host register window.
`define SNIF_LANE_W 36
`define SNIF_LANES 4
`define SNIF_PAGE_W 8
`define SNIF_OFFS_W 22

// outstanding reads the arbiter can route back, power of two.
`define SNIF_RD_DEPTH 16

`endif

/* logic/sniffer_pkg.sv */
`include "sniffer_config.svh"

package sniffer_pkg;

  typedef logic [`SNIF_LANE_W-1:0] lane_t;  // one host lane.

  // raw on the app and dram side, four lanes in the host window.
  typedef union packed {
    logic [`SNIF_WORD_W-1:0] raw;
    lane_t [`SNIF_LANES-1:0] lane;
  } dram_word_u;

  typedef enum logic {
    REQ_APP  = 1'b0,
    REQ_HOST = 1'b1
  } req_id_e;

  typedef enum logic [2:0] {
    HREG_LANE0  = 3'd0,
    HREG_LANE1  = 3'd1,
    HREG_LANE2  = 3'd2,
    HREG_LANE3  = 3'd3,
    HREG_BE     = 3'd4,
    HREG_PAGE   = 3'd5,
    HREG_OFFS   = 3'd6,  // offset, with read select and start.
    HREG_STATUS = 3'd7
  } host_reg_e;

endpackage

/* sim.f */
+incdir+logic
logic/sniffer_pkg.sv
logic/dram_req_if.sv
logic/host_window.sv
logic/dram_arbiter.sv
logic/dram_cmd_stage.sv
logic/dram_sniffer_top.sv
test/tb_dram_sniffer.sv

/* test/tb_dram_sniffer.sv */
`timescale 1ns/1ns
`include "sniffer_config.svh"

module tb_dram_sniffer;
  import sniffer_pkg::*;

  localparam int SEED        = 32'hb33c;
  localparam int N_APP       = 40;  // application commands per phase.
  localparam int N_PAIRS     = 6;   // host write and read back pairs.
  localparam int N_OPS       = 2 * N_APP + 4 * N_PAIRS + 8;
  localparam int WATCHDOG_NS = N_OPS * 40 * 40 + 20000;

  typedef struct packed {
    logic [`SNIF_ADDR_W-1:0] addr;
    logic                    rnw;
    logic [`SNIF_BE_W-1:0]   be;
    dram_word_u              data;
  } cmd_t;

  logic                    dram_clk = 1'b0;
  logic                    reset;
  logic                    phy_ready;
  logic [`SNIF_ADDR_W-1:0] dram_cmd_addr;
  logic                    dram_cmd_rnw;
  logic                    dram_cmd_valid;
  logic [`SNIF_WORD_W-1:0] dram_wr_data;
  logic [`SNIF_BE_W-1:0]   dram_wr_be;
  logic [`SNIF_WORD_W-1:0] dram_rd_data;
  logic                    dram_rd_valid;
  logic                    dram_fifo_ready;
  logic [`SNIF_ADDR_W-1:0] app_cmd_addr;
  logic                    app_cmd_rnw;
  logic                    app_cmd_valid;
  logic                    app_cmd_ack;
  logic [`SNIF_WORD_W-1:0] app_wr_data;
  logic [`SNIF_BE_W-1:0]   app_wr_be;
  logic [`SNIF_WORD_W-1:0] app_rd_data;
  logic                    app_rd_valid;
  logic                    host_wr;
  logic                    host_rd;
  host_reg_e               host_reg;
  lane_t                   host_wdata;
  lane_t                   host_rdata;

  integer     app_seed  = SEED;
  integer     host_seed = SEED + 1;
  integer     dram_seed = SEED + 2;
  cmd_t       app_cmd_q[$];   // expected commands, app space.
  cmd_t       host_cmd_q[$];  // expected commands, host space has addr bit 31 set.
  dram_word_u app_exp_q[$];
  dram_word_u rd_word_q[$];   // dram model read returns.
  int         rd_due_q[$];
  dram_word_u shadow[logic [31:0]];
  dram_word_u dram_mem[logic [31:0]];
  int         cycle    = 0;
  int         last_due = 0;
  cmd_t       held;
  logic       prev_valid;
  logic       prev_ready;
  logic       prev_phy;

  dram_sniffer_top UUT (.*);

  always #20 dram_clk = ~dram_clk;

  ////////////////////
  // reference helpers.
  function automatic dram_word_u fill_word(input logic [31:0] a);
    dram_word_u w;
    w.raw = {a ^ 32'h9e37_79b9, ~a, a ^ 32'h5a5a_a5a5, {a[15:0], a[31:16]}, a[31:16] ^ a[15:0]};
    return w;
  endfunction

  function automatic dram_word_u merge_be(input dram_word_u old_w, input dram_word_u new_w,
                                          input logic [`SNIF_BE_W-1:0] be);
    dram_word_u w;
    w = old_w;
    for (int b = 0; b < `SNIF_BE_W; b++) begin
      if (be[b]) w.raw[b*8 +: 8] = new_w.raw[b*8 +: 8];  // one enable per byte.
    end
    return w;
  endfunction

  function automatic dram_word_u shadow_rd(input logic [31:0] a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  function automatic dram_word_u mem_word(input logic [31:0] a);
    return dram_mem.exists(a) ? dram_mem[a] : fill_word(a);
  endfunction

  function automatic dram_word_u rand_word(inout integer s);
    dram_word_u w;
    w.raw = '0;
    for (int i = 0; i < 5; i++) begin
      w.raw = {w.raw[`SNIF_WORD_W-33:0], 32'($random(s))};
    end
    return w;
  endfunction

  ////////////////////
  // compare tasks.
  task automatic stop_run();
    $display("Verification failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %b, actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_word(input string name, input dram_word_u exp, input dram_word_u act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_lane(input string name, input lane_t exp, input lane_t act);
    if (act !== exp) begin
      $display("Error at %0t ns: %s expected %h, actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_cmd(input cmd_t exp);
    if (dram_cmd_addr !== exp.addr) begin
      $display("Error at %0t ns: dram_cmd_addr expected %h, actual %h",
               $time, exp.addr, dram_cmd_addr);
      stop_run();
    end
    check_bit("dram_cmd_rnw", exp.rnw, dram_cmd_rnw);
    if (dram_wr_be !== exp.be) begin
      $display("Error at %0t ns: dram_wr_be expected %h, actual %h", $time, exp.be, dram_wr_be);
      stop_run();
    end
  endtask

  ////////////////////
  // dram model and monitor.
  always @(negedge dram_clk) begin
    integer r;
    r = $random(dram_seed);
    dram_fifo_ready = (r[1:0] != 2'b00);  // ready three cycles in four.
    if (rd_due_q.size() > 0 && rd_due_q[0] <= cycle) begin
      dram_rd_valid = 1'b1;
      dram_rd_data  = rd_word_q.pop_front();
      void'(rd_due_q.pop_front());
    end else begin
      dram_rd_valid = 1'b0;
    end
  end

  always @(posedge dram_clk) begin
    cmd_t c;
    int   due;
    cycle++;
    if (!reset) begin
      if (!phy_ready && app_cmd_ack) begin
        $display("app_cmd_ack pulsed while phy_ready was low");
        stop_run();
      end
      if (dram_cmd_valid && !prev_valid && !prev_phy) begin
        $display("dram_cmd_valid rose after a cycle with phy_ready low");
        stop_run();
      end
      if (prev_valid && !prev_ready) begin
        check_bit("dram_cmd_valid", 1'b1, dram_cmd_valid);
        check_cmd(held);
        check_word("dram_wr_data", held.data, dram_wr_data);
      end
      if (app_rd_valid) begin
        if (app_exp_q.size() == 0) begin
          $display("read data reached the application port with no read outstanding");
          stop_run();
        end else begin
          check_word("app_rd_data", app_exp_q.pop_front(), app_rd_data);
        end
      end
      if (dram_cmd_valid && dram_fifo_ready) begin
        if ((dram_cmd_addr[31] ? host_cmd_q.size() : app_cmd_q.size()) == 0) begin
          $display("DRAM command at %h matches no outstanding request", dram_cmd_addr);
          stop_run();
        end else begin
          c = dram_cmd_addr[31] ? host_cmd_q.pop_front() : app_cmd_q.pop_front();
          check_cmd(c);
          if (!c.rnw) begin
            check_word("dram_wr_data", c.data, dram_wr_data);
            dram_mem[c.addr] = merge_be(mem_word(c.addr), dram_wr_data, dram_wr_be);
          end else begin
            due = cycle + 2 + ($unsigned($random(dram_seed)) % 5);  // reads stay in order.
            if (due <= last_due) due = last_due + 1;
            last_due = due;
            rd_due_q.push_back(due);
            rd_word_q.push_back(mem_word(c.addr));
          end
        end
      end
    end
    held       = '{dram_cmd_addr, dram_cmd_rnw, dram_wr_be, dram_wr_data};
    prev_valid = dram_cmd_valid;
    prev_ready = dram_fifo_ready;
    prev_phy   = phy_ready;
  end

  ////////////////////
  // requestor tasks.
  task automatic app_op();
    integer          r;
    logic [31:0]     a;
    dram_word_u      d;
    cmd_t            c;
    r = $random(app_seed);
    a = {26'd0, r[5:0]};
    d = rand_word(app_seed);
    @(negedge dram_clk);
    app_cmd_addr  = a;
    app_cmd_rnw   = r[31];
    app_wr_data   = d.raw;
    app_wr_be     = r[29:12];
    app_cmd_valid = 1'b1;
    do begin
      @(posedge dram_clk);
    end while (!app_cmd_ack);
    c = '{a << 2, r[31], r[29:12], d};  // byte address is the word address times four.
    app_cmd_q.push_back(c);
    if (r[31]) app_exp_q.push_back(shadow_rd(c.addr));
    else shadow[c.addr] = merge_be(shadow_rd(c.addr), d, c.be);
    @(negedge dram_clk);
    app_cmd_valid = 1'b0;
  endtask

  task automatic host_write(input host_reg_e r, input lane_t d);
    @(negedge dram_clk);
    host_reg   = r;
    host_wdata = d;
    host_wr    = 1'b1;
    @(negedge dram_clk);
    host_wr = 1'b0;
  endtask

  task automatic host_read(input host_reg_e r, output lane_t d);
    @(negedge dram_clk);
    host_reg = r;
    host_rd  = 1'b1;
    @(negedge dram_clk);
    host_rd = 1'b0;
    d = host_rdata;
  endtask

  task automatic host_wait_idle();
    lane_t st;
    do begin
      host_read(HREG_STATUS, st);
    end while (st[0]);
  endtask

  task automatic host_issue(input logic [7:0] pg, input logic [21:0] off, input logic rnw,
                            input dram_word_u w, input logic [`SNIF_BE_W-1:0] be);
    cmd_t c;
    c = '{{pg, off, 2'b00}, rnw, be, w};
    if (!rnw) begin
      for (int i = 0; i < `SNIF_LANES; i++) host_write(host_reg_e'(i), w.lane[i]);
      shadow[c.addr] = merge_be(shadow_rd(c.addr), w, be);
    end
    host_write(HREG_BE, lane_t'(be));
    host_write(HREG_PAGE, lane_t'(pg));
    host_cmd_q.push_back(c);
    host_write(HREG_OFFS, {rnw, 1'b1, 12'd0, off});  // bit 34 starts the command.
  endtask

  task automatic host_pair();
    integer     r;
    logic [7:0] pg;
    logic [21:0] off;
    dram_word_u w;
    dram_word_u exp;
    lane_t      v;
    r   = $random(host_seed);
    pg  = {5'b10000, r[2:0]};
    off = {19'd0, r[5:3]};
    w   = rand_word(host_seed);
    host_issue(pg, off, 1'b0, w, r[29:12]);
    host_wait_idle();
    host_issue(pg, off, 1'b1, w, r[29:12]);
    host_wait_idle();
    exp = shadow_rd({pg, off, 2'b00});
    for (int i = 0; i < `SNIF_LANES; i++) begin
      host_read(host_reg_e'(i), v);
      check_lane($sformatf("host lane%0d", i), exp.lane[i], v);
    end
  endtask

  task automatic drain();
    while (app_cmd_q.size() || host_cmd_q.size() || app_exp_q.size() || rd_due_q.size() ||
           dram_cmd_valid) begin
      @(negedge dram_clk);
    end
  endtask

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout: traffic did not complete within %0d ns", WATCHDOG_NS);
    stop_run();
  end

  ////////////////////
  // test sequence.
  initial begin
    lane_t      st;
    dram_word_u pw;
    reset           = 1'b1;
    phy_ready       = 1'b1;
    dram_rd_data    = '0;
    dram_rd_valid   = 1'b0;
    dram_fifo_ready = 1'b0;
    app_cmd_addr    = '0;
    app_cmd_rnw     = 1'b0;
    app_cmd_valid   = 1'b0;
    app_wr_data     = '0;
    app_wr_be       = '0;
    host_wr         = 1'b0;
    host_rd         = 1'b0;
    host_reg        = HREG_LANE0;
    host_wdata      = '0;
    repeat (3) @(posedge dram_clk);
    @(negedge dram_clk);
    reset = 1'b0;
    @(posedge dram_clk);
    check_bit("dram_cmd_valid", 1'b0, dram_cmd_valid);
    check_bit("app_cmd_ack", 1'b0, app_cmd_ack);
    check_bit("app_rd_valid", 1'b0, app_rd_valid);
    host_read(HREG_STATUS, st);
    check_lane("host status", lane_t'(2'b10), st);
    repeat (N_APP) app_op();
    host_pair();
    fork
      repeat (N_APP) app_op();
      repeat (N_PAIRS) host_pair();
    join
    drain();
    // phy down, both requestors wait.
    @(negedge dram_clk);
    phy_ready = 1'b0;
    pw        = rand_word(host_seed);
    fork
      app_op();
      begin
        host_issue(8'h9c, 22'h3f, 1'b0, pw, '1);
        repeat (8) @(negedge dram_clk);
        host_read(HREG_STATUS, st);
        check_lane("host status", lane_t'(2'b01), st);
        phy_ready = 1'b1;
        host_wait_idle();
      end
    join
    drain();
    $display("Verification passed");
    $finish;
  end

endmodule
